// ==== design/command_fields.sv ====
/*
 * Pulls the command word fields out of the bit stream while a command
 * sync word is in flight. With BC at 0 the sync marks a status word.
 */
`default_nettype none

module command_fields #(
   parameter bit BC = 1'b1
) (
   input  wire                     dec_clk,
   input  wire                     rst_n,
   input  wire                     bit_in,
   input  wire                     bit_sample,
   input  wire dec_1553_pkg::bit_idx_t bit_idx,
   input  wire                     is_csw,
   input  wire                     lastword,
   output dec_1553_pkg::field_t    rt_address,
   output logic                    tr,
   output dec_1553_pkg::field_t    sub_address,
   output dec_1553_pkg::field_t    dwcnt_mcode
);

   localparam dec_1553_pkg::bit_idx_t SA_FIRST = dec_1553_pkg::TR_BIT + 5'd1;
   localparam dec_1553_pkg::bit_idx_t WC_FIRST = dec_1553_pkg::SA_LAST_BIT + 5'd1;

   logic csw_sample;
   logic cmd_sample;

   function automatic logic in_cells(input dec_1553_pkg::bit_idx_t idx,
                                     input dec_1553_pkg::bit_idx_t first,
                                     input dec_1553_pkg::bit_idx_t last);
      return (idx >= first) && (idx <= last);
   endfunction

   assign csw_sample = is_csw && bit_sample;
   // Status words carry only the RT address in this layout
   assign cmd_sample = csw_sample && BC;

   //////////////////////////////
   // Field capture
   //////////////////////////////

   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         rt_address <= '0;
      end else if (lastword) begin
         rt_address <= '0;
      end else if (csw_sample && in_cells(bit_idx, '0, dec_1553_pkg::RT_LAST_BIT)) begin
         rt_address <= {rt_address[1:4], bit_in};
      end
   end

   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         tr <= 1'b0;
      end else if (lastword) begin
         tr <= 1'b0;
      end else if (cmd_sample && (bit_idx == dec_1553_pkg::TR_BIT)) begin
         tr <= bit_in;
      end
   end

   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         sub_address <= '0;
      end else if (lastword) begin
         sub_address <= '0;
      end else if (cmd_sample && in_cells(bit_idx, SA_FIRST, dec_1553_pkg::SA_LAST_BIT)) begin
         sub_address <= {sub_address[1:4], bit_in};
      end
   end

   // Word count survives lastword
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         dwcnt_mcode <= '0;
      end else if (cmd_sample && in_cells(bit_idx, WC_FIRST, dec_1553_pkg::WC_LAST_BIT)) begin
         dwcnt_mcode <= {dwcnt_mcode[1:4], bit_in};
      end
   end

endmodule

`default_nettype wire

// ==== design/dec_1553_core.sv ====
/*
 * Top level of the 1553 receive decoder. Wires the line sampler, word
 * timer, word assembler and command field capture together.
 */
`default_nettype none

module dec_1553_core #(
   // 1 when the decoder listens for commands, 0 for status words
   parameter bit BC = 1'b1
) (
   input  wire                        dec_clk,
   input  wire                        rst_n,
   input  wire                        rx_data,
   input  wire                        lastword,
   output wire dec_1553_pkg::word_t   rx_dword,
   output wire                        rx_dval,
   output wire                        rx_csw,
   output wire                        rx_dw,
   output wire                        rx_perr,
   output wire dec_1553_pkg::field_t  rt_address,
   output wire                        tr,
   output wire dec_1553_pkg::field_t  sub_address,
   output wire dec_1553_pkg::field_t  dwcnt_mcode
);

   wire                          sync_csw;
   wire                          sync_dw;
   wire                          bit_in;
   wire                          word_active;
   wire                          bit_sample;
   wire dec_1553_pkg::bit_idx_t  bit_idx;
   wire                          word_done;

   manchester_sampler u_sampler (
      .dec_clk  (dec_clk),
      .rst_n    (rst_n),
      .rx_data  (rx_data),
      .sync_csw (sync_csw),
      .sync_dw  (sync_dw),
      .bit_in   (bit_in)
   );

   // Word type levels double as the rx_csw and rx_dw outputs
   word_timer u_timer (
      .dec_clk     (dec_clk),
      .rst_n       (rst_n),
      .sync_csw    (sync_csw),
      .sync_dw     (sync_dw),
      .word_active (word_active),
      .bit_sample  (bit_sample),
      .bit_idx     (bit_idx),
      .word_done   (word_done),
      .is_csw      (rx_csw),
      .is_dw       (rx_dw)
   );

   word_assembler u_assembler (
      .dec_clk     (dec_clk),
      .rst_n       (rst_n),
      .bit_in      (bit_in),
      .bit_sample  (bit_sample),
      .word_active (word_active),
      .word_done   (word_done),
      .rx_dword    (rx_dword),
      .rx_dval     (rx_dval),
      .rx_perr     (rx_perr)
   );

   command_fields #(
      .BC (BC)
   ) u_fields (
      .dec_clk     (dec_clk),
      .rst_n       (rst_n),
      .bit_in      (bit_in),
      .bit_sample  (bit_sample),
      .bit_idx     (bit_idx),
      .is_csw      (rx_csw),
      .lastword    (lastword),
      .rt_address  (rt_address),
      .tr          (tr),
      .sub_address (sub_address),
      .dwcnt_mcode (dwcnt_mcode)
   );

endmodule

`default_nettype wire

// ==== design/dec_1553_pkg.sv ====
/*
 * Widths, word types and bus constants for the 1553 receive decoder.
 * RTL blocks and the testbench refer to these by scoped name.
 */
`default_nettype none

package dec_1553_pkg;

   //////////////////////////////
   // Line timing
   //////////////////////////////

   // dec_clk cycles in one bit cell
   localparam int SAMPLES_PER_BIT = 8;
   localparam int WORD_BITS       = 16;
   localparam int SYNC_VARIANTS   = 4;

   //////////////////////////////
   // Types
   //////////////////////////////

   // Index 0 is the first bit on the bus
   typedef logic [0:WORD_BITS-1] word_t;
   typedef logic [0:4] field_t;
   typedef logic [4:0] bit_idx_t;
   typedef logic [7:0] sample_cnt_t;
   // Three bit cells of samples with the oldest sample at index 0
   typedef logic [0:3*SAMPLES_PER_BIT-1] sync_win_t;

   //////////////////////////////
   // Word layout
   //////////////////////////////

   // Sample count at which data and parity are complete
   localparam sample_cnt_t WORD_END_CNT = 8'd131;
   localparam bit_idx_t    PARITY_BIT   = 5'd16;

   // Last bit cell of each command word field
   localparam bit_idx_t RT_LAST_BIT = 5'd4;
   localparam bit_idx_t TR_BIT      = 5'd5;
   localparam bit_idx_t SA_LAST_BIT = 5'd10;
   localparam bit_idx_t WC_LAST_BIT = 5'd15;

   // Command/status sync as nominal, one sample late, one sample early and short high half
   localparam sync_win_t SYNC_CSW_PATTERNS [SYNC_VARIANTS] =
      '{24'hFFF000, 24'h7FF800, 24'hFFE001, 24'h7FF000};

   // Data sync uses the same variants with the line inverted
   localparam sync_win_t SYNC_DW_PATTERNS [SYNC_VARIANTS] =
      '{24'h000FFF, 24'h8007FF, 24'h001FFE, 24'h800FFF};

endpackage

`default_nettype wire

// ==== design/manchester_sampler.sv ====
/*
 * Line front end of the decoder. Registers rx_data, keeps a three-cell
 * sample window and flags the sync type. The inverted sample feeds the word logic.
 */
`default_nettype none

module manchester_sampler (
   input  wire  dec_clk,
   input  wire  rst_n,
   input  wire  rx_data,
   output logic sync_csw,
   output logic sync_dw,
   output logic bit_in
);

   logic [4:0]                in_sr;
   dec_1553_pkg::sync_win_t   sync_win;
   logic                      line_edge;
   logic                      match_csw;
   logic                      match_dw;
   logic                      match_csw_d;
   logic                      match_dw_d;

   //////////////////////////////
   // Input stages and window
   //////////////////////////////

   // in_sr[0] is the newest sample; the window trails the last stage
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         in_sr    <= '0;
         sync_win <= '0;
      end else begin
         in_sr    <= {in_sr[3:0], rx_data};
         sync_win <= {sync_win[1:$high(sync_win)], in_sr[4]};
      end
   end

   // Mid-cell transition of bit 0 lands here as the window fills
   assign line_edge = in_sr[0] ^ in_sr[1];

   //////////////////////////////
   // Sync recognition
   //////////////////////////////

   always_comb begin
      match_csw = 1'b0;
      match_dw  = 1'b0;
      for (int i = 0; i < dec_1553_pkg::SYNC_VARIANTS; i++) begin
         match_csw = match_csw | (sync_win == dec_1553_pkg::SYNC_CSW_PATTERNS[i]);
         match_dw  = match_dw  | (sync_win == dec_1553_pkg::SYNC_DW_PATTERNS[i]);
      end
   end

   // Stretch the match so an edge one sample late still qualifies
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         match_csw_d <= 1'b0;
         match_dw_d  <= 1'b0;
      end else begin
         match_csw_d <= match_csw;
         match_dw_d  <= match_dw;
      end
   end

   assign sync_csw = (match_csw | match_csw_d) & line_edge;
   assign sync_dw  = (match_dw  | match_dw_d)  & line_edge;

   // Second half of the cell carries the inverse of the bit
   assign bit_in = ~in_sr[0];

   a_sync_exclusive : assert property (
      @(posedge dec_clk) disable iff (!rst_n)
      !(sync_csw && sync_dw)
   ) else $error("command and data sync seen together");

endmodule

`default_nettype wire

// ==== design/word_assembler.sv ====
/*
 * Shifts in the 16 data bits and the parity bit of a word, then
 * presents the word for one cycle with rx_dval and the odd parity check.
 */
`default_nettype none

module word_assembler (
   input  wire                  dec_clk,
   input  wire                  rst_n,
   input  wire                  bit_in,
   input  wire                  bit_sample,
   input  wire                  word_active,
   input  wire                  word_done,
   output dec_1553_pkg::word_t  rx_dword,
   output logic                 rx_dval,
   output logic                 rx_perr
);

   // Data bits 0 to 15, parity in the last place
   logic [0:dec_1553_pkg::WORD_BITS] shift_sr;

   always_ff @(posedge dec_clk) begin
      if (!word_active) begin
         shift_sr <= '0;
      end else if (bit_sample) begin
         shift_sr <= {shift_sr[1:dec_1553_pkg::WORD_BITS], bit_in};
      end
   end

   // Word shows only in the rx_dval cycle
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_dword <= '0;
         rx_dval  <= 1'b0;
         rx_perr  <= 1'b0;
      end else if (word_done) begin
         rx_dword <= shift_sr[0:dec_1553_pkg::WORD_BITS-1];
         rx_dval  <= 1'b1;
         // Odd parity over data plus parity bit
         rx_perr  <= ~(^shift_sr);
      end else begin
         rx_dword <= '0;
         rx_dval  <= 1'b0;
         rx_perr  <= 1'b0;
      end
   end

   a_perr_with_dval : assert property (
      @(posedge dec_clk) disable iff (!rst_n)
      rx_perr |-> rx_dval
   ) else $error("parity error flagged without a valid word");

   a_dval_single : assert property (
      @(posedge dec_clk) disable iff (!rst_n)
      rx_dval |=> !rx_dval
   ) else $error("rx_dval held for more than one cycle");

endmodule

`default_nettype wire

// ==== design/word_timer.sv ====
/*
 * Paces one word after a sync. Runs the sample counter, marks the bit
 * sample points and holds the sync type until the word has been delivered.
 */
`default_nettype none

module word_timer (
   input  wire                    dec_clk,
   input  wire                    rst_n,
   input  wire                    sync_csw,
   input  wire                    sync_dw,
   output logic                   word_active,
   output logic                   bit_sample,
   output dec_1553_pkg::bit_idx_t bit_idx,
   output logic                   word_done,
   output logic                   is_csw,
   output logic                   is_dw
);

   localparam int PHASE_W = $clog2(dec_1553_pkg::SAMPLES_PER_BIT);

   dec_1553_pkg::sample_cnt_t cnt;
   logic                      start;
   logic                      word_done_d;

   assign start = sync_csw | sync_dw;

   // Counter idles at all ones and restarts at zero on every sync
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         word_active <= 1'b0;
         cnt         <= '1;
      end else if (start) begin
         word_active <= 1'b1;
         cnt         <= '0;
      end else if (word_done) begin
         word_active <= 1'b0;
         cnt         <= '1;
      end else if (word_active) begin
         cnt <= cnt + 1'b1;
      end
   end

   assign word_done  = word_active && (cnt == dec_1553_pkg::WORD_END_CNT);
   // One sample point per cell, 17 cells in all
   assign bit_sample = word_active && (cnt[PHASE_W-1:0] == '0);

   // Cell index, stays on the parity cell once it gets there
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_idx <= '0;
      end else if (start || !word_active) begin
         bit_idx <= '0;
      end else if (bit_sample && (bit_idx < dec_1553_pkg::PARITY_BIT)) begin
         bit_idx <= bit_idx + 1'b1;
      end
   end

   //////////////////////////////
   // Word type
   //////////////////////////////

   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         is_csw      <= 1'b0;
         is_dw       <= 1'b0;
         word_done_d <= 1'b0;
      end else begin
         word_done_d <= word_done;
         if (sync_csw) begin
            is_csw <= 1'b1;
            is_dw  <= 1'b0;
         end else if (sync_dw) begin
            is_csw <= 1'b0;
            is_dw  <= 1'b1;
         end else if (word_done_d) begin
            // Held through the rx_dval cycle
            is_csw <= 1'b0;
            is_dw  <= 1'b0;
         end
      end
   end

   a_bit_idx_range : assert property (
      @(posedge dec_clk) disable iff (!rst_n)
      word_active |-> (bit_idx <= dec_1553_pkg::PARITY_BIT)
   ) else $error("bit index beyond the parity cell");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the 1553 decoder testbench with Verilator and runs it.
# Exit status is 0 only when the log holds a pass and no failure.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f sim.f \
   --top-module tb_dec_1553

# The log decides the result, so a crashed run is caught below
./obj_dir/Vtb_dec_1553 > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi

if ! grep -q ">>> PASS" sim.log; then
   echo "Simulation ended without a result, see sim.log"
   exit 1
fi

echo "Simulation passed"

// ==== sim.f ====
+incdir+include
design/dec_1553_pkg.sv
design/manchester_sampler.sv
design/word_timer.sv
design/word_assembler.sv
design/command_fields.sv
design/dec_1553_core.sv
sim/tb_dec_1553.sv

// ==== include/tb_dec_1553_vectors.svh ====
/*
 * Vector table for the 1553 decoder testbench, included inside the testbench module.
 * Each row gives one word on the line and what the decoder must show for it.
 */
`ifndef TB_DEC_1553_VECTORS_SVH
`define TB_DEC_1553_VECTORS_SVH

// Columns: sync type, word, bad parity, lastword after
//          expected word, perr, csw, dw, rt_address, tr, sub_address, dwcnt_mcode
typedef struct packed {
   logic                 is_cmd;
   dec_1553_pkg::word_t  word;
   logic                 bad_par;
   logic                 pulse_lw;
   dec_1553_pkg::word_t  exp_word;
   logic                 exp_perr;
   logic                 exp_csw;
   logic                 exp_dw;
   dec_1553_pkg::field_t exp_rt;
   logic                 exp_tr;
   dec_1553_pkg::field_t exp_sa;
   dec_1553_pkg::field_t exp_wc;
} vector_t;

localparam logic SYNC_CMD  = 1'b1;
localparam logic SYNC_DATA = 1'b0;

localparam int NUM_VECTORS = 9;

// Command words are written as {rt_address, tr, sub_address, dwcnt_mcode}
localparam vector_t VECTORS [NUM_VECTORS] = '{
   '{SYNC_CMD,  {5'd3, 1'b1, 5'd17, 5'd4}, 1'b0, 1'b0,
     {5'd3, 1'b1, 5'd17, 5'd4}, 1'b0, 1'b1, 1'b0, 5'd3, 1'b1, 5'd17, 5'd4},
   '{SYNC_DATA, 16'hA5C3, 1'b0, 1'b0,
     16'hA5C3, 1'b0, 1'b0, 1'b1, 5'd3, 1'b1, 5'd17, 5'd4},
   '{SYNC_DATA, 16'h0000, 1'b0, 1'b0,
     16'h0000, 1'b0, 1'b0, 1'b1, 5'd3, 1'b1, 5'd17, 5'd4},
   // Inverted parity bit, word still delivered
   '{SYNC_DATA, 16'hFFFF, 1'b1, 1'b0,
     16'hFFFF, 1'b1, 1'b0, 1'b1, 5'd3, 1'b1, 5'd17, 5'd4},
   '{SYNC_CMD,  {5'd30, 1'b0, 5'd2, 5'd31}, 1'b0, 1'b1,
     {5'd30, 1'b0, 5'd2, 5'd31}, 1'b0, 1'b1, 1'b0, 5'd30, 1'b0, 5'd2, 5'd31},
   // Only the word count is left after lastword
   '{SYNC_DATA, 16'h1234, 1'b0, 1'b0,
     16'h1234, 1'b0, 1'b0, 1'b1, 5'd0, 1'b0, 5'd0, 5'd31},
   '{SYNC_CMD,  {5'd21, 1'b1, 5'd0, 5'd9}, 1'b1, 1'b0,
     {5'd21, 1'b1, 5'd0, 5'd9}, 1'b1, 1'b1, 1'b0, 5'd21, 1'b1, 5'd0, 5'd9},
   '{SYNC_DATA, 16'h8001, 1'b0, 1'b1,
     16'h8001, 1'b0, 1'b0, 1'b1, 5'd21, 1'b1, 5'd0, 5'd9},
   '{SYNC_CMD,  {5'd31, 1'b1, 5'd31, 5'd0}, 1'b0, 1'b0,
     {5'd31, 1'b1, 5'd31, 5'd0}, 1'b0, 1'b1, 1'b0, 5'd31, 1'b1, 5'd31, 5'd0}
};

`endif

// ==== sim/tb_dec_1553.sv ====
/*
 * Testbench for the 1553 receive decoder. Sends Manchester words on rx_data
 * from the vector table, then random data words, and checks every decoded word.
 */
`default_nettype none

module tb_dec_1553;

   localparam int RANDOM_SEED   = 3;
   localparam int NUM_RANDOM    = 6;
   localparam int HALF_CELL     = dec_1553_pkg::SAMPLES_PER_BIT / 2;
   localparam int DVAL_WAIT_MAX = 40;

   `include "tb_dec_1553_vectors.svh"

   // About 170 cycles per word, rounded up
   localparam int TIMEOUT_CYCLES = (NUM_VECTORS + NUM_RANDOM) * 200 + 500;

   logic                 dec_clk;
   logic                 rst_n;
   logic                 rx_data;
   logic                 lastword;
   dec_1553_pkg::word_t  rx_dword;
   logic                 rx_dval;
   logic                 rx_csw;
   logic                 rx_dw;
   logic                 rx_perr;
   dec_1553_pkg::field_t rt_address;
   logic                 tr;
   dec_1553_pkg::field_t sub_address;
   dec_1553_pkg::field_t dwcnt_mcode;

   int mismatches = 0;
   int failures   = 0;
   int cycles     = 0;
   int words_sent = 0;
   int dval_seen  = 0;

   dec_1553_core #(
      .BC (1'b1)
   ) dut (
      .dec_clk     (dec_clk),
      .rst_n       (rst_n),
      .rx_data     (rx_data),
      .lastword    (lastword),
      .rx_dword    (rx_dword),
      .rx_dval     (rx_dval),
      .rx_csw      (rx_csw),
      .rx_dw       (rx_dw),
      .rx_perr     (rx_perr),
      .rt_address  (rt_address),
      .tr          (tr),
      .sub_address (sub_address),
      .dwcnt_mcode (dwcnt_mcode)
   );

   initial begin
      dec_clk = 1'b0;
      forever #4 dec_clk = ~dec_clk;
   end

   always @(posedge dec_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run still going after %0d cycles", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Every rx_dval pulse, wanted or not
   always @(negedge dec_clk) begin
      if (rst_n && rx_dval) begin
         dval_seen <= dval_seen + 1;
      end
   end

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_word(input string name, input dec_1553_pkg::word_t got,
                             input dec_1553_pkg::word_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_field(input string name, input dec_1553_pkg::field_t got,
                              input dec_1553_pkg::field_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_outputs(input dec_1553_pkg::word_t w, input logic dval,
                                input logic perr, input logic csw, input logic dw,
                                input dec_1553_pkg::field_t rt, input logic trv,
                                input dec_1553_pkg::field_t sa,
                                input dec_1553_pkg::field_t wc);
      check_bit("rx_dval", rx_dval, dval);
      check_word("rx_dword", rx_dword, w);
      check_bit("rx_perr", rx_perr, perr);
      check_bit("rx_csw", rx_csw, csw);
      check_bit("rx_dw", rx_dw, dw);
      check_field("rt_address", rt_address, rt);
      check_bit("tr", tr, trv);
      check_field("sub_address", sub_address, sa);
      check_field("dwcnt_mcode", dwcnt_mcode, wc);
   endtask

   //////////////////////////////
   // Line driver
   //////////////////////////////

   task automatic drive_level(input logic level, input int samples);
      repeat (samples) begin
         @(negedge dec_clk);
         rx_data <= level;
      end
   endtask

   // Sync, 16 data cells, then the parity cell
   task automatic send_word(input logic is_cmd, input dec_1553_pkg::word_t w,
                            input logic bad_par);
      logic par;
      par = bad_par ? (^w) : ~(^w);
      // Command sync starts high, data sync starts low
      drive_level(is_cmd, 3 * HALF_CELL);
      drive_level(~is_cmd, 3 * HALF_CELL);
      for (int i = 0; i < dec_1553_pkg::WORD_BITS; i++) begin
         drive_level(w[i], HALF_CELL);
         drive_level(~w[i], HALF_CELL);
      end
      drive_level(par, HALF_CELL);
      drive_level(~par, HALF_CELL);
      words_sent++;
   endtask

   task automatic wait_dval(output bit seen);
      seen = 1'b0;
      for (int n = 0; n < DVAL_WAIT_MAX && !seen; n++) begin
         @(negedge dec_clk);
         seen = rx_dval;
      end
   endtask

   task automatic run_word(input vector_t v);
      bit seen;
      send_word(v.is_cmd, v.word, v.bad_par);
      wait_dval(seen);
      if (!seen) begin
         failures++;
         $display("No rx_dval within %0d cycles after word %h", DVAL_WAIT_MAX, v.word);
      end else begin
         check_outputs(v.exp_word, 1'b1, v.exp_perr, v.exp_csw, v.exp_dw,
                       v.exp_rt, v.exp_tr, v.exp_sa, v.exp_wc);
         // One cycle later the word and its type are gone, fields stay
         @(negedge dec_clk);
         check_outputs('0, 1'b0, 1'b0, 1'b0, 1'b0, v.exp_rt, v.exp_tr, v.exp_sa, v.exp_wc);
      end
      if (v.pulse_lw) begin
         lastword <= 1'b1;
         @(negedge dec_clk);
         lastword <= 1'b0;
         check_outputs('0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 5'd0, v.exp_wc);
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      vector_t     v;
      vector_t     model;
      logic [31:0] rnd;
      int          idle_cycles;
      rst_n    = 1'b0;
      rx_data  = 1'b0;
      lastword = 1'b0;
      void'($urandom(RANDOM_SEED));
      repeat (3) @(posedge dec_clk);
      @(negedge dec_clk);
      rst_n <= 1'b1;

      // Idle line after reset
      rnd = $urandom;
      idle_cycles = 16 + int'(rnd[5:0]);
      repeat (idle_cycles) begin
         @(negedge dec_clk);
         check_outputs('0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 5'd0, 5'd0);
      end

      model = VECTORS[0];
      for (int i = 0; i < NUM_VECTORS; i++) begin
         run_word(VECTORS[i]);
         model = VECTORS[i];
         if (model.pulse_lw) begin
            model.exp_rt = '0;
            model.exp_tr = 1'b0;
            model.exp_sa = '0;
         end
      end

      // Random data words straight after the last command word
      for (int i = 0; i < NUM_RANDOM; i++) begin
         rnd        = $urandom;
         v          = model;
         v.is_cmd   = SYNC_DATA;
         v.word     = rnd[15:0];
         v.bad_par  = 1'b0;
         v.pulse_lw = 1'b0;
         v.exp_word = rnd[15:0];
         v.exp_perr = 1'b0;
         v.exp_csw  = 1'b0;
         v.exp_dw   = 1'b1;
         run_word(v);
      end

      repeat (4) @(negedge dec_clk);
      if (dval_seen != words_sent) begin
         failures++;
         $display("Saw %0d rx_dval pulses for %0d words sent", dval_seen, words_sent);
      end
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches + failures == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
